/* bench/sd_wb_tb.sv */
`timescale 1ns/1ps

module sd_wb_tb;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	localparam int FIFO_DEPTH   = 4;
	localparam int SEED         = 3242;
	localparam int ACCESS_LIMIT = 100;
	// about 85 accesses are issued, none needs more than 25 cycles
	localparam int ACCESS_COUNT  = 100;
	localparam int ACCESS_CYCLES = 25;
	localparam int WATCHDOG_NS = (RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES) * CLK_PERIOD;

	logic wb_clock;
	logic rst_n;
	logic strobe;
	logic we;
	sd_wb_pkg::wb_adr_t adr;
	sd_wb_pkg::wb_data_t wr_data;
	logic ack;
	logic err;
	sd_wb_pkg::wb_data_t rd_data;
	logic write_wait;
	logic read_wait;
	logic cmd_done;
	logic data_done;
	logic tx_pop;
	logic host_valid;
	sd_wb_pkg::wb_data_t host_data;
	logic cmd_start;
	logic data_start;
	sd_wb_pkg::wb_data_t cmd_arg;
	sd_wb_pkg::wb_data_t tx_data;

	// reference models of the slave
	sd_wb_pkg::wb_data_t ref_regs [sd_wb_pkg::REG_COUNT];
	sd_wb_pkg::wb_data_t tx_ref [$];
	sd_wb_pkg::wb_data_t rx_ref [$];
	sd_wb_pkg::wb_data_t arg_shadow;

	// expected answer of the access in flight
	logic want_ack;
	logic check_data;
	sd_wb_pkg::wb_data_t want_data;
	logic hold_ack;
	logic data_phase;

	int cmd_starts = 0;
	int data_starts = 0;
	int errors;
	int test_errors;
	int tests_passed;
	int tests_failed;

	sd_wb_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut_i (
		.wb_clock_i        (wb_clock),
		.rst_n_i           (rst_n),
		.strobe_i          (strobe),
		.we_i              (we),
		.adr_i             (adr),
		.wb_data_i         (wr_data),
		.ack_o             (ack),
		.error_o           (err),
		.wb_data_o         (rd_data),
		.fifo_write_wait_o (write_wait),
		.fifo_read_wait_o  (read_wait),
		.cmd_done_i        (cmd_done),
		.data_done_i       (data_done),
		.sd_tx_pop_i       (tx_pop),
		.host_data_valid_i (host_valid),
		.host_data_i       (host_data),
		.cmd_start_o       (cmd_start),
		.data_start_o      (data_start),
		.cmd_arg_o         (cmd_arg),
		.sd_tx_data_o      (tx_data)
	);

	initial
	begin
		wb_clock = 1'b0;
		forever #(CLK_PERIOD / 2) wb_clock = ~wb_clock;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// start pulses as the SD engines see them
	always @(negedge wb_clock)
	begin
		if (cmd_start)
			cmd_starts++;
		if (data_start)
			data_starts++;
	end

	function automatic void report_mismatch(input string msg);
		errors++;
		$display("Error at %0d ns: %s", $time, msg);
	endfunction

	function automatic sd_wb_pkg::wb_data_t random_word();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	function automatic void expect_response(input logic ok, input logic check,
		input sd_wb_pkg::wb_data_t data);
		want_ack   = ok;
		check_data = check;
		want_data  = data;
	endfunction

	function automatic void begin_test();
		test_errors = errors;
	endfunction

	function automatic void end_test(input string name);
		if (errors == test_errors)
		begin
			tests_passed++;
			$display("test %s: pass", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: fail with %0d errors", name, errors - test_errors);
		end
	endfunction

	// response class follows the address map
	assert property (@(negedge wb_clock) disable iff (!rst_n) (ack || err) |-> (ack == want_ack))
		else report_mismatch(want_ack ? "error_o where ack_o was expected"
			: "ack_o where error_o was expected");

	assert property (@(negedge wb_clock) disable iff (!rst_n)
		(ack && check_data) |-> (rd_data == want_data))
		else report_mismatch($sformatf("read data %h, expected %h", rd_data, want_data));

	// nothing may finish while the SD side still holds the access
	assert property (@(negedge wb_clock) disable iff (!rst_n) hold_ack |-> !ack)
		else report_mismatch("ack_o came while the access was still held");

	assert property (@(negedge wb_clock) disable iff (!rst_n)
		(cmd_start || data_start) |-> (cmd_arg == arg_shadow))
		else report_mismatch($sformatf("argument %h, expected %h", cmd_arg, arg_shadow));

	assert property (@(negedge wb_clock) disable iff (!rst_n) data_phase |-> !cmd_start)
		else report_mismatch("cmd_start_o pulsed during a data execute");

	// one access, called and returning on a falling edge
	task automatic bus_access(input logic write, input sd_wb_pkg::wb_adr_t address,
		input sd_wb_pkg::wb_data_t data);
		int cycles;
		cycles = 0;
		strobe = 1'b1;
		we = write;
		adr = address;
		wr_data = data;
		@(negedge wb_clock);
		while (!ack && !err && cycles < ACCESS_LIMIT)
		begin
			@(negedge wb_clock);
			cycles++;
		end
		if (!ack && !err)
		begin
			errors++;
			$display("no answer to the access at address %0d within %0d cycles", address,
				ACCESS_LIMIT);
		end
		strobe = 1'b0;
		// gap before the next strobe
		@(negedge wb_clock);
	endtask

	task automatic read_all_registers();
		for (int i = 0; i < sd_wb_pkg::REG_COUNT; i++)
		begin
			expect_response(1'b1, 1'b1, ref_regs[i]);
			bus_access(1'b0, sd_wb_pkg::wb_adr_t'(i), '0);
		end
	endtask

	task automatic check_registers();
		sd_wb_pkg::reg_idx_t idx;
		sd_wb_pkg::wb_data_t word;
		begin_test();
		for (int n = 0; n < 24; n++)
		begin
			idx = sd_wb_pkg::reg_idx_t'($urandom());
			word = random_word();
			expect_response(1'b1, 1'b0, '0);
			bus_access(1'b1, sd_wb_pkg::wb_adr_t'(idx), word);
			ref_regs[idx] = word;
		end
		read_all_registers();
		end_test("registers");
	endtask

	task automatic check_bad_access();
		begin_test();
		expect_response(1'b0, 1'b0, '0);
		for (int a = 20; a < 32; a++)
			bus_access(1'($urandom()), sd_wb_pkg::wb_adr_t'(a), random_word());
		bus_access(1'b0, sd_wb_pkg::ADR_CMD_EXEC, '0);
		bus_access(1'b0, sd_wb_pkg::ADR_FIFO_WRITE, '0);
		bus_access(1'b0, sd_wb_pkg::ADR_DATA_EXEC, '0);
		bus_access(1'b1, sd_wb_pkg::ADR_FIFO_READ, random_word());
		// register contents must survive all of the above
		read_all_registers();
		end_test("bad_access");
	endtask

	task automatic run_exec(input logic use_data);
		sd_wb_pkg::wb_data_t arg;
		int pause;
		int cmd_before;
		int data_before;
		arg = random_word();
		pause = 3 + int'($urandom() % 10);
		cmd_before = cmd_starts;
		data_before = data_starts;
		arg_shadow = arg;
		data_phase = use_data;
		hold_ack = 1'b1;
		expect_response(1'b1, 1'b0, '0);
		fork
			bus_access(1'b1, use_data ? sd_wb_pkg::ADR_DATA_EXEC : sd_wb_pkg::ADR_CMD_EXEC, arg);
			begin
				repeat (pause) @(negedge wb_clock);
				hold_ack = 1'b0;
				if (use_data)
					data_done = 1'b1;
				else
					cmd_done = 1'b1;
			end
		join
		cmd_done = 1'b0;
		data_done = 1'b0;
		data_phase = 1'b0;
		assert (cmd_starts - cmd_before == (use_data ? 0 : 1))
			else report_mismatch($sformatf("%0d cmd_start_o pulses", cmd_starts - cmd_before));
		assert (data_starts - data_before == (use_data ? 1 : 0))
			else report_mismatch($sformatf("%0d data_start_o pulses", data_starts - data_before));
	endtask

	// checks the head against the reference, then pops it for one cycle
	task automatic pop_tx_word();
		sd_wb_pkg::wb_data_t expected;
		expected = tx_ref.pop_front();
		assert (tx_data == expected)
			else report_mismatch($sformatf("tx head %h, expected %h", tx_data, expected));
		tx_pop = 1'b1;
		@(negedge wb_clock);
		tx_pop = 1'b0;
	endtask

	task automatic fill_and_drain_tx();
		sd_wb_pkg::wb_data_t word;
		int writes;
		begin_test();
		writes = 0;
		expect_response(1'b1, 1'b0, '0);
		while (!write_wait && writes < 2 * FIFO_DEPTH)
		begin
			word = random_word();
			tx_ref.push_back(word);
			bus_access(1'b1, sd_wb_pkg::ADR_FIFO_WRITE, word);
			writes++;
		end
		assert (writes == FIFO_DEPTH)
			else report_mismatch($sformatf("write wait rose after %0d writes", writes));
		// one more write stalls until the engine takes a word
		word = random_word();
		tx_ref.push_back(word);
		hold_ack = 1'b1;
		fork
			bus_access(1'b1, sd_wb_pkg::ADR_FIFO_WRITE, word);
			begin
				repeat (6) @(negedge wb_clock);
				hold_ack = 1'b0;
				pop_tx_word();
			end
		join
		while (tx_ref.size() > 0)
			pop_tx_word();
		assert (!write_wait) else report_mismatch("write wait still high after draining");
		end_test("tx_fifo");
	endtask

	task automatic collect_rx();
		sd_wb_pkg::wb_data_t words [3];
		begin_test();
		foreach (words[i])
		begin
			words[i] = random_word();
			rx_ref.push_back(words[i]);
		end
		assert (read_wait) else report_mismatch("read wait low with an empty receive FIFO");
		hold_ack = 1'b1;
		expect_response(1'b1, 1'b1, rx_ref.pop_front());
		fork
			bus_access(1'b0, sd_wb_pkg::ADR_FIFO_READ, '0);
			begin
				repeat (5) @(negedge wb_clock);
				hold_ack = 1'b0;
				foreach (words[i])
				begin
					host_data = words[i];
					host_valid = 1'b1;
					@(negedge wb_clock);
				end
				host_valid = 1'b0;
			end
		join
		while (rx_ref.size() > 0)
		begin
			expect_response(1'b1, 1'b1, rx_ref.pop_front());
			bus_access(1'b0, sd_wb_pkg::ADR_FIFO_READ, '0);
		end
		assert (read_wait) else report_mismatch("read wait low after every word was read");
		end_test("rx_fifo");
	endtask

	initial
	begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		strobe = 1'b0;
		we = 1'b0;
		adr = '0;
		wr_data = '0;
		cmd_done = 1'b0;
		data_done = 1'b0;
		tx_pop = 1'b0;
		host_valid = 1'b0;
		host_data = '0;
		arg_shadow = '0;
		hold_ack = 1'b0;
		data_phase = 1'b0;
		expect_response(1'b1, 1'b0, '0);
		errors = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < sd_wb_pkg::REG_COUNT; i++)
			ref_regs[i] = '0;

		repeat (RESET_CYCLES) @(negedge wb_clock);
		rst_n = 1'b1;
		@(negedge wb_clock);

		begin_test();
		assert (!ack && !err && !cmd_start && !data_start)
			else report_mismatch("response or start output high after reset");
		assert (!write_wait && read_wait) else report_mismatch("FIFO wait flags wrong after reset");
		end_test("reset");

		check_registers();
		check_bad_access();
		begin_test();
		run_exec(1'b0);
		run_exec(1'b0);
		end_test("cmd_exec");
		begin_test();
		run_exec(1'b1);
		run_exec(1'b1);
		end_test("data_exec");
		fill_and_drain_tx();
		collect_rx();

		$display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed,
			tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* logic/sd_exec_ctrl.sv */
`timescale 1ns/1ps

module sd_exec_ctrl (
	input  logic                wb_clock_i,
	input  logic                rst_n_i,
	input  logic                cmd_go_i,
	input  logic                data_go_i,
	input  sd_wb_pkg::wb_data_t arg_i,
	input  logic                cmd_done_i,
	input  logic                data_done_i,
	output logic                cmd_start_o,
	output logic                data_start_o,
	output sd_wb_pkg::wb_data_t cmd_arg_o,
	output logic                exec_done_o
);

	typedef enum logic [1:0] {
		IDLE,
		CMD_BUSY,
		DATA_BUSY
	} exec_state_e;

	exec_state_e state_q;

	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q      <= IDLE;
			cmd_start_o  <= 1'b0;
			data_start_o <= 1'b0;
		end
		else
		begin
			cmd_start_o  <= 1'b0;
			data_start_o <= 1'b0;
			case (state_q)
				IDLE:
				begin
					if (cmd_go_i)
					begin
						cmd_start_o <= 1'b1;
						state_q     <= CMD_BUSY;
					end
					else if (data_go_i)
					begin
						data_start_o <= 1'b1;
						state_q      <= DATA_BUSY;
					end
				end
				CMD_BUSY:
					if (cmd_done_i)
						state_q <= IDLE;
				DATA_BUSY:
					if (data_done_i)
						state_q <= IDLE;
				default:
					state_q <= IDLE;
			endcase
		end
	end

	// argument held for the engine through the whole operation
	always_ff @(posedge wb_clock_i)
	begin
		if ((state_q == IDLE) && (cmd_go_i || data_go_i))
			cmd_arg_o <= arg_i;
	end

	// done levels only count while the matching engine is busy
	assign exec_done_o = ((state_q == CMD_BUSY) && cmd_done_i) ||
		((state_q == DATA_BUSY) && data_done_i);

	assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		(cmd_start_o || data_start_o) |=> !(cmd_start_o || data_start_o));

	// decoder never launches while an engine is still running
	assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		(state_q != IDLE) |-> !(cmd_go_i || data_go_i));

endmodule

/* logic/sd_reg_bank.sv */
`timescale 1ns/1ps

module sd_reg_bank (
	input  logic                wb_clock_i,
	input  logic                rst_n_i,
	input  logic                wr_i,
	input  sd_wb_pkg::reg_idx_t idx_i,
	input  sd_wb_pkg::wb_data_t wdata_i,
	output sd_wb_pkg::wb_data_t rdata_o
);

	sd_wb_pkg::wb_data_t regs_q [sd_wb_pkg::REG_COUNT];

	// all registers clear on reset
	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < sd_wb_pkg::REG_COUNT; i++)
				regs_q[i] <= '0;
		end
		else if (wr_i)
		begin
			regs_q[idx_i] <= wdata_i;
		end
	end

	// read path is combinational, sampled by the response stage
	assign rdata_o = regs_q[idx_i];

endmodule

/* logic/sd_wb_decode.sv */
`timescale 1ns/1ps

module sd_wb_decode (
	input  logic               wb_clock_i,
	input  logic               rst_n_i,
	input  logic               strobe_i,
	input  logic               we_i,
	input  sd_wb_pkg::wb_adr_t adr_i,
	input  logic               tx_full_i,
	input  logic               rx_empty_i,
	input  logic               exec_done_i,
	output logic               reg_wr_o,
	output logic               fifo_push_o,
	output logic               fifo_pop_o,
	output logic               cmd_go_o,
	output logic               data_go_o,
	output logic               resp_ok_o,
	output logic               resp_err_o,
	output logic               rd_from_fifo_o
);

	sd_wb_pkg::dec_state_e state_q;
	logic accept;
	logic is_reg;
	logic is_cmd;
	logic is_data;
	logic is_fwr;
	logic is_frd;

	// new access seen in idle
	assign accept = (state_q == sd_wb_pkg::IDLE) && strobe_i;

	assign is_reg  = (adr_i < sd_wb_pkg::wb_adr_t'(sd_wb_pkg::REG_COUNT));
	assign is_cmd  = we_i && (adr_i == sd_wb_pkg::ADR_CMD_EXEC);
	assign is_data = we_i && (adr_i == sd_wb_pkg::ADR_DATA_EXEC);
	assign is_fwr  = we_i && (adr_i == sd_wb_pkg::ADR_FIFO_WRITE);
	assign is_frd  = !we_i && (adr_i == sd_wb_pkg::ADR_FIFO_READ);

	// go straight from the accepting cycle so the start pulse follows that edge
	assign cmd_go_o  = accept && is_cmd;
	assign data_go_o = accept && is_data;

	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q        <= sd_wb_pkg::IDLE;
			reg_wr_o       <= 1'b0;
			fifo_push_o    <= 1'b0;
			fifo_pop_o     <= 1'b0;
			resp_ok_o      <= 1'b0;
			resp_err_o     <= 1'b0;
			rd_from_fifo_o <= 1'b0;
		end
		else
		begin
			reg_wr_o       <= 1'b0;
			fifo_push_o    <= 1'b0;
			fifo_pop_o     <= 1'b0;
			resp_ok_o      <= 1'b0;
			resp_err_o     <= 1'b0;
			rd_from_fifo_o <= 1'b0;
			case (state_q)
				sd_wb_pkg::IDLE:
				begin
					if (strobe_i)
					begin
						if (is_reg)
						begin
							reg_wr_o  <= we_i;
							resp_ok_o <= 1'b1;
							state_q   <= sd_wb_pkg::RESPOND;
						end
						else if (is_cmd || is_data)
							state_q <= sd_wb_pkg::WAIT_EXEC;
						else if (is_fwr || is_frd)
							state_q <= sd_wb_pkg::WAIT_FIFO;
						else
						begin
							resp_err_o <= 1'b1;
							state_q    <= sd_wb_pkg::RESPOND;
						end
					end
				end
				sd_wb_pkg::WAIT_FIFO:
				begin
					// hold here until there is room or data
					if (we_i && !tx_full_i)
					begin
						fifo_push_o <= 1'b1;
						resp_ok_o   <= 1'b1;
						state_q     <= sd_wb_pkg::RESPOND;
					end
					else if (!we_i && !rx_empty_i)
					begin
						fifo_pop_o     <= 1'b1;
						rd_from_fifo_o <= 1'b1;
						resp_ok_o      <= 1'b1;
						state_q        <= sd_wb_pkg::RESPOND;
					end
				end
				sd_wb_pkg::WAIT_EXEC:
				begin
					if (exec_done_i)
					begin
						resp_ok_o <= 1'b1;
						state_q   <= sd_wb_pkg::RESPOND;
					end
				end
				sd_wb_pkg::RESPOND:
				begin
					// master drops strobe once it sees the response
					if (!strobe_i)
						state_q <= sd_wb_pkg::IDLE;
				end
				default:
					state_q <= sd_wb_pkg::IDLE;
			endcase
		end
	end

	// one action per cycle across registered and direct pulses
	assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		$onehot0({reg_wr_o, fifo_push_o, fifo_pop_o, cmd_go_o, data_go_o}));

endmodule

/* logic/sd_wb_fifo.sv */
`timescale 1ns/1ps

module sd_wb_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                wb_clock_i,
	input  logic                rst_n_i,
	input  logic                push_i,
	input  logic                pop_i,
	input  sd_wb_pkg::wb_data_t wdata_i,
	output sd_wb_pkg::wb_data_t rdata_o,
	output logic                full_o,
	output logic                empty_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	sd_wb_pkg::wb_data_t mem_q [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;

	// requests against a full or empty buffer are dropped here
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
	assign empty_o = (count_q == '0);
	assign rdata_o = mem_q[rd_ptr_q];

	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			// pointers wrap on their own, depth is a power of two
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge wb_clock_i)
	begin
		if (do_push)
			mem_q[wr_ptr_q] <= wdata_i;
	end

	assert property (@(posedge wb_clock_i) disable iff (!rst_n_i) push_i |-> !full_o);
	assert property (@(posedge wb_clock_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

/* logic/sd_wb_pkg.sv */
package sd_wb_pkg;

	// bus and fifo payload word
	typedef logic [127:0] wb_data_t;

	// bus address, 32 slots of which 20 are mapped
	typedef logic [4:0] wb_adr_t;

	// register index, low bits of a register address
	typedef logic [3:0] reg_idx_t;

	// address map above the register window
	localparam wb_adr_t ADR_CMD_EXEC   = 5'd16;
	localparam wb_adr_t ADR_FIFO_WRITE = 5'd17;
	localparam wb_adr_t ADR_FIFO_READ  = 5'd18;
	localparam wb_adr_t ADR_DATA_EXEC  = 5'd19;

	localparam int REG_COUNT = 16;

	// decoder FSM
	typedef enum logic [1:0] {
		IDLE,
		WAIT_FIFO,
		WAIT_EXEC,
		RESPOND
	} dec_state_e;

endpackage

/* logic/sd_wb_resp.sv */
`timescale 1ns/1ps

module sd_wb_resp (
	input  logic                wb_clock_i,
	input  logic                rst_n_i,
	input  logic                resp_ok_i,
	input  logic                resp_err_i,
	input  logic                rd_from_fifo_i,
	input  sd_wb_pkg::wb_data_t reg_rdata_i,
	input  sd_wb_pkg::wb_data_t fifo_rdata_i,
	output logic                ack_o,
	output logic                error_o,
	output sd_wb_pkg::wb_data_t wb_data_o
);

	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ack_o   <= 1'b0;
			error_o <= 1'b0;
		end
		else
		begin
			ack_o   <= resp_ok_i;
			error_o <= resp_err_i;
		end
	end

	// fifo head is captured on the same edge that pops it
	always_ff @(posedge wb_clock_i)
	begin
		if (resp_ok_i)
			wb_data_o <= rd_from_fifo_i ? fifo_rdata_i : reg_rdata_i;
	end

	assert property (@(posedge wb_clock_i) disable iff (!rst_n_i) !(ack_o && error_o));

	// one response per access, the decoder parks until strobe drops
	assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		(ack_o || error_o) |=> !(ack_o || error_o));

endmodule

/* logic/sd_wb_top.sv */
`timescale 1ns/1ps

module sd_wb_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                wb_clock_i,
	input  logic                rst_n_i,
	input  logic                strobe_i,
	input  logic                we_i,
	input  sd_wb_pkg::wb_adr_t  adr_i,
	input  sd_wb_pkg::wb_data_t wb_data_i,
	output logic                ack_o,
	output logic                error_o,
	output sd_wb_pkg::wb_data_t wb_data_o,
	output logic                fifo_write_wait_o,
	output logic                fifo_read_wait_o,
	input  logic                cmd_done_i,
	input  logic                data_done_i,
	input  logic                sd_tx_pop_i,
	input  logic                host_data_valid_i,
	input  sd_wb_pkg::wb_data_t host_data_i,
	output logic                cmd_start_o,
	output logic                data_start_o,
	output sd_wb_pkg::wb_data_t cmd_arg_o,
	output sd_wb_pkg::wb_data_t sd_tx_data_o
);

	logic reg_wr;
	logic fifo_push;
	logic fifo_pop;
	logic cmd_go;
	logic data_go;
	logic resp_ok;
	logic resp_err;
	logic rd_from_fifo;
	logic exec_done;
	sd_wb_pkg::wb_data_t reg_rdata;
	sd_wb_pkg::wb_data_t rx_rdata;

	sd_wb_decode decode_i (
		.wb_clock_i     (wb_clock_i),
		.rst_n_i        (rst_n_i),
		.strobe_i       (strobe_i),
		.we_i           (we_i),
		.adr_i          (adr_i),
		.tx_full_i      (fifo_write_wait_o),
		.rx_empty_i     (fifo_read_wait_o),
		.exec_done_i    (exec_done),
		.reg_wr_o       (reg_wr),
		.fifo_push_o    (fifo_push),
		.fifo_pop_o     (fifo_pop),
		.cmd_go_o       (cmd_go),
		.data_go_o      (data_go),
		.resp_ok_o      (resp_ok),
		.resp_err_o     (resp_err),
		.rd_from_fifo_o (rd_from_fifo)
	);

	// register index is the low part of the address
	sd_reg_bank reg_bank_i (
		.wb_clock_i (wb_clock_i),
		.rst_n_i    (rst_n_i),
		.wr_i       (reg_wr),
		.idx_i      (adr_i[3:0]),
		.wdata_i    (wb_data_i),
		.rdata_o    (reg_rdata)
	);

	sd_exec_ctrl exec_ctrl_i (
		.wb_clock_i   (wb_clock_i),
		.rst_n_i      (rst_n_i),
		.cmd_go_i     (cmd_go),
		.data_go_i    (data_go),
		.arg_i        (wb_data_i),
		.cmd_done_i   (cmd_done_i),
		.data_done_i  (data_done_i),
		.cmd_start_o  (cmd_start_o),
		.data_start_o (data_start_o),
		.cmd_arg_o    (cmd_arg_o),
		.exec_done_o  (exec_done)
	);

	// host to card, popped by the data engine
	sd_wb_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
		.wb_clock_i (wb_clock_i),
		.rst_n_i    (rst_n_i),
		.push_i     (fifo_push),
		.pop_i      (sd_tx_pop_i),
		.wdata_i    (wb_data_i),
		.rdata_o    (sd_tx_data_o),
		.full_o     (fifo_write_wait_o),
		.empty_o    ()
	);

	// card to host, filled by the data engine
	sd_wb_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
		.wb_clock_i (wb_clock_i),
		.rst_n_i    (rst_n_i),
		.push_i     (host_data_valid_i),
		.pop_i      (fifo_pop),
		.wdata_i    (host_data_i),
		.rdata_o    (rx_rdata),
		.full_o     (),
		.empty_o    (fifo_read_wait_o)
	);

	sd_wb_resp resp_i (
		.wb_clock_i     (wb_clock_i),
		.rst_n_i        (rst_n_i),
		.resp_ok_i      (resp_ok),
		.resp_err_i     (resp_err),
		.rd_from_fifo_i (rd_from_fifo),
		.reg_rdata_i    (reg_rdata),
		.fifo_rdata_i   (rx_rdata),
		.ack_o          (ack_o),
		.error_o        (error_o),
		.wb_data_o      (wb_data_o)
	);

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module sd_wb_tb -f vlog.f -o sd_wb_sim &&
./obj_dir/sd_wb_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }

/* vlog.f */
logic/sd_wb_pkg.sv
logic/sd_wb_fifo.sv
logic/sd_reg_bank.sv
logic/sd_exec_ctrl.sv
logic/sd_wb_decode.sv
logic/sd_wb_resp.sv
logic/sd_wb_top.sv
bench/sd_wb_tb.sv
